// ==== rtl/mmul_pkg.sv ====
// Sizes and APB map; a store of Dim*Dim words must fit its 0x100 window, so Dim is at most 8
`default_nettype none

package mmul_pkg;

  // Default job shape, overridden only through mmul_wrap parameters
  localparam int unsigned Dim   = 4;
  localparam int unsigned DataW = 8;
  localparam int unsigned AccW  = 32;

  localparam int unsigned ApbAddrW = 12;
  localparam int unsigned ApbDataW = 32;

  typedef logic [ApbAddrW-1:0] apb_addr_t;
  typedef logic [ApbDataW-1:0] apb_data_t;
  typedef logic [AccW-1:0]     acc_t;

  // Register offsets
  localparam apb_addr_t CtrlAddr   = 12'h000;
  localparam apb_addr_t StatusAddr = 12'h004;

  // Element (i, j) sits at base + 4 * (i * Dim + j)
  localparam apb_addr_t XBase = 12'h100;
  localparam apb_addr_t WBase = 12'h200;
  localparam apb_addr_t ZBase = 12'h300;

  // Write one to start, ignored while busy
  localparam int unsigned CtrlStartBit = 0;

  localparam int unsigned StatusBusyBit = 0;
  localparam int unsigned StatusDoneBit = 1;

endpackage

`default_nettype wire

// ==== rtl/mmul_apb_regs.sv ====
// APB slave behind registered ports; answers once per access and waits for penable low
`timescale 1ns/1ps
`default_nettype none

module mmul_apb_regs #(
  parameter  int unsigned Dim   = mmul_pkg::Dim,
  parameter  int unsigned DataW = mmul_pkg::DataW,
  localparam int unsigned Elems = Dim * Dim,
  localparam int unsigned IdxW  = $clog2(Elems),
  localparam int unsigned KW    = $clog2(Dim)
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               psel_i,
  input  logic                               penable_i,
  input  logic                               pwrite_i,
  input  logic [mmul_pkg::ApbAddrW-1:0]      paddr_i,
  input  logic [mmul_pkg::ApbDataW-1:0]      pwdata_i,
  output logic [mmul_pkg::ApbDataW-1:0]      prdata_o,
  output logic                               pready_o,
  output logic                               pslverr_o,
  input  logic                               busy_i,
  input  logic                               done_i,
  output logic                               start_o,
  input  logic [KW-1:0]                      op_k_i,
  output logic [Dim-1:0][DataW-1:0]          x_col_o,
  output logic [Dim-1:0][DataW-1:0]          w_row_o,
  output logic [IdxW-1:0]                    z_raddr_o,
  input  logic [mmul_pkg::AccW-1:0]          z_rdata_i
);

  localparam mmul_pkg::apb_addr_t StoreSpan = mmul_pkg::apb_addr_t'(4 * Elems);

  logic [DataW-1:0] x_q [Elems];
  logic [DataW-1:0] w_q [Elems];

  logic                served_q;
  logic                start_q;
  logic                access;
  logic                is_ctrl;
  logic                is_status;
  logic                in_x;
  logic                in_w;
  logic                in_z;
  logic                err;
  logic [IdxW-1:0]     idx;
  mmul_pkg::apb_data_t rdata;

  function automatic mmul_pkg::apb_data_t sext(logic [DataW-1:0] v);
    return mmul_pkg::apb_data_t'($signed(v));
  endfunction

  // One answer per access phase
  assign access = psel_i & penable_i & ~served_q;

  // Byte lanes are ignored, word index only
  assign idx = paddr_i[IdxW+1:2];

  assign is_ctrl   = (paddr_i == mmul_pkg::CtrlAddr);
  assign is_status = (paddr_i == mmul_pkg::StatusAddr);
  assign in_x = (paddr_i >= mmul_pkg::XBase) && (paddr_i < mmul_pkg::XBase + StoreSpan);
  assign in_w = (paddr_i >= mmul_pkg::WBase) && (paddr_i < mmul_pkg::WBase + StoreSpan);
  assign in_z = (paddr_i >= mmul_pkg::ZBase) && (paddr_i < mmul_pkg::ZBase + StoreSpan);

  always_comb begin
    err   = 1'b0;
    rdata = '0;
    if (is_ctrl) begin
      rdata = '0;
    end else if (is_status) begin
      rdata[mmul_pkg::StatusBusyBit] = busy_i;
      rdata[mmul_pkg::StatusDoneBit] = done_i;
    end else if (in_x) begin
      rdata = sext(x_q[idx]);
      err   = pwrite_i & busy_i;
    end else if (in_w) begin
      rdata = sext(w_q[idx]);
      err   = pwrite_i & busy_i;
    end else if (in_z) begin
      rdata = z_rdata_i;
      err   = pwrite_i;
    end else begin
      err = 1'b1;
    end
  end

  assign pready_o  = access;
  assign pslverr_o = access & err;
  assign prdata_o  = (access & ~pwrite_i) ? rdata : '0;

  assign z_raddr_o = idx;
  assign start_o   = start_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      served_q <= 1'b0;
      start_q  <= 1'b0;
    end else begin
      start_q <= access & pwrite_i & is_ctrl & pwdata_i[mmul_pkg::CtrlStartBit] & ~busy_i;
      if (access) begin
        served_q <= 1'b1;
      end else if (!penable_i) begin
        served_q <= 1'b0;
      end
    end
  end

  // Operand stores, locked while a job runs
  always_ff @(posedge clk_i) begin
    if (access && pwrite_i && !err) begin
      if (in_x) begin
        x_q[idx] <= pwdata_i[DataW-1:0];
      end
      if (in_w) begin
        w_q[idx] <= pwdata_i[DataW-1:0];
      end
    end
  end

  // Slice for step k: column k of X, row k of W
  always_comb begin
    for (int i = 0; i < Dim; i++) begin
      x_col_o[i] = x_q[i * Dim + int'(op_k_i)];
      w_row_o[i] = w_q[int'(op_k_i) * Dim + i];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mmul_operand_feeder.sv ====
// Steps k once per start; busy covers the engine pipeline and drain, so it falls with done
`timescale 1ns/1ps
`default_nettype none

module mmul_operand_feeder #(
  parameter  int unsigned Dim  = mmul_pkg::Dim,
  localparam int unsigned KW   = $clog2(Dim),
  localparam int unsigned Last = Dim + 2,
  localparam int unsigned CntW = $clog2(Last + 1)
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          start_i,
  output logic          busy_o,
  output logic [KW-1:0] op_k_o,
  output logic          op_valid_o,
  output logic          op_first_o,
  output logic          op_last_o
);

  logic            busy_q;
  logic [CntW-1:0] cnt_q;

  // Count runs past the last k to cover two engine stages and the drain capture
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i && !busy_q) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (busy_q) begin
      if (cnt_q == CntW'(Last)) begin
        busy_q <= 1'b0;
      end
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign busy_o     = busy_q;
  assign op_valid_o = busy_q && (cnt_q < CntW'(Dim));
  assign op_k_o     = cnt_q[KW-1:0];

  // Engines clear on first and flag the row on last
  assign op_first_o = op_valid_o && (cnt_q == '0);
  assign op_last_o  = op_valid_o && (cnt_q == CntW'(Dim - 1));

endmodule

`default_nettype wire

// ==== rtl/mmul_row_engine.sv ====
// One row of Z; products and sums are signed, DataW up to 12 keeps them inside 32 bits
`timescale 1ns/1ps
`default_nettype none

module mmul_row_engine #(
  parameter  int unsigned Dim   = mmul_pkg::Dim,
  parameter  int unsigned DataW = mmul_pkg::DataW,
  localparam int unsigned ProdW = 2 * DataW
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              op_valid_i,
  input  logic                              op_first_i,
  input  logic                              op_last_i,
  input  logic [DataW-1:0]                  x_i,
  input  logic [Dim-1:0][DataW-1:0]         w_row_i,
  output logic                              row_valid_o,
  output logic [Dim-1:0][mmul_pkg::AccW-1:0] row_acc_o
);

  logic                               s1_valid_q;
  logic                               s1_first_q;
  logic                               s1_last_q;
  logic [Dim-1:0][ProdW-1:0]          prod_q;
  logic [Dim-1:0][mmul_pkg::AccW-1:0] acc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q  <= 1'b0;
      s1_first_q  <= 1'b0;
      s1_last_q   <= 1'b0;
      row_valid_o <= 1'b0;
    end else begin
      s1_valid_q  <= op_valid_i;
      s1_first_q  <= op_first_i;
      s1_last_q   <= op_last_i;
      row_valid_o <= s1_valid_q & s1_last_q;
    end
  end

  // Stage one, x times every W element of the row
  always_ff @(posedge clk_i) begin
    if (op_valid_i) begin
      for (int j = 0; j < Dim; j++) begin
        prod_q[j] <= $signed(x_i) * $signed(w_row_i[j]);
      end
    end
  end

  // Stage two, accumulate or restart on the first step
  always_ff @(posedge clk_i) begin
    if (s1_valid_q) begin
      for (int j = 0; j < Dim; j++) begin
        if (s1_first_q) begin
          acc_q[j] <= mmul_pkg::acc_t'($signed(prod_q[j]));
        end else begin
          acc_q[j] <= acc_q[j] + mmul_pkg::acc_t'($signed(prod_q[j]));
        end
      end
    end
  end

  assign row_acc_o = acc_q;

endmodule

`default_nettype wire

// ==== rtl/mmul_result_drain.sv ====
// Z store keeps the last job until the next capture; Dim must be a power of two
`timescale 1ns/1ps
`default_nettype none

module mmul_result_drain #(
  parameter  int unsigned Dim   = mmul_pkg::Dim,
  localparam int unsigned Elems = Dim * Dim,
  localparam int unsigned IdxW  = $clog2(Elems)
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        start_i,
  input  logic [Dim-1:0]                              row_valid_i,
  input  logic [Dim-1:0][Dim-1:0][mmul_pkg::AccW-1:0] row_acc_i,
  input  logic [IdxW-1:0]                             z_raddr_i,
  output logic                                        done_o,
  output logic [mmul_pkg::AccW-1:0]                   z_rdata_o
);

  logic [mmul_pkg::AccW-1:0] z_q [Elems];
  logic                      cap_q;
  logic                      done_q;

  // All rows finish together, capture one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cap_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      cap_q <= &row_valid_i;
      if (start_i) begin
        done_q <= 1'b0;
      end else if (cap_q) begin
        done_q <= 1'b1;
      end
    end
  end

  // Accumulators hold after the last step, so they are still stable here
  always_ff @(posedge clk_i) begin
    if (cap_q) begin
      for (int i = 0; i < Dim; i++) begin
        for (int j = 0; j < Dim; j++) begin
          z_q[i * Dim + j] <= row_acc_i[i][j];
        end
      end
    end
  end

  assign done_o    = done_q;
  assign z_rdata_o = z_q[z_raddr_i];

endmodule

`default_nettype wire

// ==== rtl/mmul_wrap.sv ====
// All ports registered once, so each APB access sees two wait states; irq is the done level
`timescale 1ns/1ps
`default_nettype none

module mmul_wrap #(
  parameter  int unsigned Dim   = mmul_pkg::Dim,
  parameter  int unsigned DataW = mmul_pkg::DataW,
  localparam int unsigned IdxW  = $clog2(Dim * Dim),
  localparam int unsigned KW    = $clog2(Dim)
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [mmul_pkg::ApbAddrW-1:0] paddr_i,
  input  logic [mmul_pkg::ApbDataW-1:0] pwdata_i,
  output logic [mmul_pkg::ApbDataW-1:0] prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,
  output logic                          irq_o
);

  logic                                        psel;
  logic                                        penable;
  logic                                        pwrite;
  logic [mmul_pkg::ApbAddrW-1:0]               paddr;
  logic [mmul_pkg::ApbDataW-1:0]               pwdata;
  logic [mmul_pkg::ApbDataW-1:0]               prdata;
  logic                                        pready;
  logic                                        pslverr;

  logic                                        start;
  logic                                        busy;
  logic                                        done;
  logic [KW-1:0]                               op_k;
  logic                                        op_valid;
  logic                                        op_first;
  logic                                        op_last;
  logic [Dim-1:0][DataW-1:0]                   x_col;
  logic [Dim-1:0][DataW-1:0]                   w_row;
  logic [Dim-1:0]                              row_valid;
  logic [Dim-1:0][Dim-1:0][mmul_pkg::AccW-1:0] row_acc;
  logic [IdxW-1:0]                             z_raddr;
  logic [mmul_pkg::AccW-1:0]                   z_rdata;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Inputs
      psel      <= '0;
      penable   <= '0;
      pwrite    <= '0;
      paddr     <= '0;
      pwdata    <= '0;
      // Outputs
      prdata_o  <= '0;
      pready_o  <= '0;
      pslverr_o <= '0;
      irq_o     <= '0;
    end else begin
      psel      <= psel_i;
      penable   <= penable_i;
      pwrite    <= pwrite_i;
      paddr     <= paddr_i;
      pwdata    <= pwdata_i;
      prdata_o  <= prdata;
      pready_o  <= pready;
      pslverr_o <= pslverr;
      irq_o     <= done;
    end
  end

  mmul_apb_regs #(
    .Dim   ( Dim   ),
    .DataW ( DataW )
  ) i_regs (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .psel_i    ( psel    ),
    .penable_i ( penable ),
    .pwrite_i  ( pwrite  ),
    .paddr_i   ( paddr   ),
    .pwdata_i  ( pwdata  ),
    .prdata_o  ( prdata  ),
    .pready_o  ( pready  ),
    .pslverr_o ( pslverr ),
    .busy_i    ( busy    ),
    .done_i    ( done    ),
    .start_o   ( start   ),
    .op_k_i    ( op_k    ),
    .x_col_o   ( x_col   ),
    .w_row_o   ( w_row   ),
    .z_raddr_o ( z_raddr ),
    .z_rdata_i ( z_rdata )
  );

  mmul_operand_feeder #(
    .Dim ( Dim )
  ) i_feeder (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .start_i    ( start    ),
    .busy_o     ( busy     ),
    .op_k_o     ( op_k     ),
    .op_valid_o ( op_valid ),
    .op_first_o ( op_first ),
    .op_last_o  ( op_last  )
  );

  // One engine per row of Z, all fed the same W row
  for (genvar i = 0; i < Dim; i++) begin : gen_rows
    mmul_row_engine #(
      .Dim   ( Dim   ),
      .DataW ( DataW )
    ) i_row_engine (
      .clk_i       ( clk_i        ),
      .rst_ni      ( rst_ni       ),
      .op_valid_i  ( op_valid     ),
      .op_first_i  ( op_first     ),
      .op_last_i   ( op_last      ),
      .x_i         ( x_col[i]     ),
      .w_row_i     ( w_row        ),
      .row_valid_o ( row_valid[i] ),
      .row_acc_o   ( row_acc[i]   )
    );
  end

  mmul_result_drain #(
    .Dim ( Dim )
  ) i_drain (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .start_i     ( start     ),
    .row_valid_i ( row_valid ),
    .row_acc_i   ( row_acc   ),
    .z_raddr_i   ( z_raddr   ),
    .done_o      ( done      ),
    .z_rdata_o   ( z_rdata   )
  );

endmodule

`default_nettype wire

// ==== test/mmul_checker.sv ====
// Port-level APB and irq properties of mmul_wrap; attached by bind, clocked on clk_i
`timescale 1ns/1ps
`default_nettype none

module mmul_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic pready_i,
  input logic pslverr_i,
  input logic irq_i
);

  int unsigned fail_cnt = 0;

  // One answer per access, so never two ready cycles in a row
  single_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pready_i |=> !pready_i)
    else begin
      fail_cnt++;
      $error("pready_o stayed high for two consecutive cycles");
    end

  err_with_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pslverr_i |-> pready_i)
    else begin
      fail_cnt++;
      $error("pslverr_o high without pready_o");
    end

  // Output register resets to zero
  irq_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !irq_i)
    else begin
      fail_cnt++;
      $error("irq_o high during reset");
    end

endmodule

`default_nettype wire

// ==== test/mmul_monitor.sv ====
// Checks every completed APB access; Z reads are compared only once a job has finished
`timescale 1ns/1ps
`default_nettype none

module mmul_monitor #(
  parameter int unsigned Dim   = mmul_pkg::Dim,
  parameter int unsigned DataW = mmul_pkg::DataW
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [mmul_pkg::ApbAddrW-1:0] paddr_i,
  input  logic [mmul_pkg::ApbDataW-1:0] pwdata_i,
  input  logic [mmul_pkg::ApbDataW-1:0] prdata_i,
  input  logic                          pready_i,
  input  logic                          pslverr_i,
  input  logic                          irq_i,
  output int unsigned                   err_cnt_o
);

  localparam int unsigned Elems = Dim * Dim;
  localparam logic [31:0] BusyWord = 32'(1) << mmul_pkg::StatusBusyBit;
  localparam logic [31:0] DoneWord = 32'(1) << mmul_pkg::StatusDoneBit;

  int          shadow_x [Elems] = '{default: 0};
  int          shadow_w [Elems] = '{default: 0};
  int          job_x [Elems] = '{default: 0};
  int          job_w [Elems] = '{default: 0};
  logic        pending = 1'b0;
  logic        have_result = 1'b0;
  int unsigned errs = 0;

  assign err_cnt_o = errs;

  function automatic int sext(logic [31:0] v);
    logic [DataW-1:0] low;
    low = v[DataW-1:0];
    return int'($signed(low));
  endfunction

  // Z(i,j) as the sum over k of X(i,k) * W(k,j), wrapping at 32 bits
  function automatic int ref_z(int i, int j);
    int acc;
    acc = 0;
    for (int k = 0; k < int'(Dim); k++) begin
      acc = acc + job_x[i * int'(Dim) + k] * job_w[k * int'(Dim) + j];
    end
    return acc;
  endfunction

  task automatic report(string name, logic [11:0] addr, logic [31:0] got, logic [31:0] exp);
    errs++;
    $display("** Error: %s at addr %h: got %h, expected %h (t=%0t)", name, addr, got, exp,
             $time);
  endtask

  task automatic check_access();
    logic [11:0] a;
    int          idx;
    logic        is_ctrl;
    logic        is_status;
    logic        in_x;
    logic        in_w;
    logic        in_z;
    logic        exp_err;
    logic        cmp;
    logic [31:0] exp;
    a         = paddr_i;
    idx       = int'(a[7:2]);
    is_ctrl   = (a == mmul_pkg::CtrlAddr);
    is_status = (a == mmul_pkg::StatusAddr);
    in_x = (a >= mmul_pkg::XBase) && (a < mmul_pkg::XBase + 12'(4 * Elems));
    in_w = (a >= mmul_pkg::WBase) && (a < mmul_pkg::WBase + 12'(4 * Elems));
    in_z = (a >= mmul_pkg::ZBase) && (a < mmul_pkg::ZBase + 12'(4 * Elems));
    exp_err = !(is_ctrl || is_status || in_x || in_w || in_z) || (pwrite_i && in_z) ||
              (pwrite_i && (in_x || in_w) && pending);
    if (pslverr_i !== exp_err) begin
      report("pslverr_o", a, 32'(pslverr_i), 32'(exp_err));
    end
    if (pwrite_i) begin
      if (!exp_err && in_x) begin
        shadow_x[idx] = sext(pwdata_i);
      end
      if (!exp_err && in_w) begin
        shadow_w[idx] = sext(pwdata_i);
      end
      // A start while a job runs is dropped
      if (is_ctrl && pwdata_i[mmul_pkg::CtrlStartBit] && !pending) begin
        pending = 1'b1;
        job_x   = shadow_x;
        job_w   = shadow_w;
      end
    end else begin
      cmp = 1'b1;
      exp = '0;
      if (in_x) begin
        exp = 32'(shadow_x[idx]);
      end else if (in_w) begin
        exp = 32'(shadow_w[idx]);
      end else if (in_z) begin
        cmp = have_result;
        exp = 32'(ref_z(idx / int'(Dim), idx % int'(Dim)));
      end else if (is_status) begin
        if (pending) begin
          cmp = 1'b0;
          if (prdata_i === DoneWord) begin
            pending     = 1'b0;
            have_result = 1'b1;
          end else if (prdata_i !== BusyWord) begin
            report("prdata_o (status, busy or done)", a, prdata_i, BusyWord);
          end
        end else begin
          exp = have_result ? DoneWord : '0;
        end
        // irq_o and the status word leave the wrapper through the same register
        if (irq_i !== prdata_i[mmul_pkg::StatusDoneBit]) begin
          report("irq_o", a, 32'(irq_i), 32'(prdata_i[mmul_pkg::StatusDoneBit]));
        end
      end
      if (cmp && prdata_i !== exp) begin
        report("prdata_o", a, prdata_i, exp);
      end
    end
  endtask

  // Master holds its signals until after ready, so mid-cycle values are stable
  always @(negedge clk_i) begin
    if (rst_ni && psel_i && penable_i && pready_i) begin
      check_access();
    end
  end

endmodule

`default_nettype wire

// ==== test/mmul_tb.sv ====
// Runs jobs back to back with status polling; each start waits for the previous done
`timescale 1ns/1ps
`default_nettype none

module mmul_tb;

  localparam int unsigned Dim      = mmul_pkg::Dim;
  localparam int unsigned DataW    = mmul_pkg::DataW;
  localparam int unsigned Elems    = Dim * Dim;
  localparam int unsigned RandJobs = 10;
  // Register test, then per job operands, start, polls and Z reads
  localparam int unsigned PlannedXfers = 20 + (RandJobs + 4) * (3 * Elems + 12);

  logic                          clk_i;
  logic                          rst_ni;
  logic                          psel_i;
  logic                          penable_i;
  logic                          pwrite_i;
  logic [mmul_pkg::ApbAddrW-1:0] paddr_i;
  logic [mmul_pkg::ApbDataW-1:0] pwdata_i;
  logic [mmul_pkg::ApbDataW-1:0] prdata_o;
  logic                          pready_o;
  logic                          pslverr_o;
  logic                          irq_o;
  int unsigned                   mon_errs;
  int unsigned                   tb_errs = 0;
  integer                        seed = 32'h570a50fc;
  logic [31:0]                   rd;

  mmul_wrap DUT (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .psel_i    ( psel_i    ),
    .penable_i ( penable_i ),
    .pwrite_i  ( pwrite_i  ),
    .paddr_i   ( paddr_i   ),
    .pwdata_i  ( pwdata_i  ),
    .prdata_o  ( prdata_o  ),
    .pready_o  ( pready_o  ),
    .pslverr_o ( pslverr_o ),
    .irq_o     ( irq_o     )
  );

  mmul_monitor #(
    .Dim   ( Dim   ),
    .DataW ( DataW )
  ) monitor (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .psel_i    ( psel_i    ),
    .penable_i ( penable_i ),
    .pwrite_i  ( pwrite_i  ),
    .paddr_i   ( paddr_i   ),
    .pwdata_i  ( pwdata_i  ),
    .prdata_i  ( prdata_o  ),
    .pready_i  ( pready_o  ),
    .pslverr_i ( pslverr_o ),
    .irq_i     ( irq_o     ),
    .err_cnt_o ( mon_errs  )
  );

  bind mmul_wrap mmul_checker port_checker (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .pready_i  ( pready_o  ),
    .pslverr_i ( pslverr_o ),
    .irq_i     ( irq_o     )
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  function automatic logic [11:0] elem_addr(logic [11:0] base, int i, int j);
    return base + 12'(4 * (i * int'(Dim) + j));
  endfunction

  // Setup, then access until ready is seen mid-cycle
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    while (!pready_o) begin
      @(negedge clk_i);
    end
    rd = prdata_o;
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic wait_done();
    do begin
      apb_xfer(1'b0, mmul_pkg::StatusAddr, '0);
    end while (!rd[mmul_pkg::StatusDoneBit]);
    @(negedge clk_i);
    if (irq_o !== 1'b1) begin
      tb_errs++;
      $display("** Error: irq_o after done: got %h, expected %h", irq_o, 1'b1);
    end
  endtask

  // kind 0 random, 1 identity X with random W, 2 all most negative
  task automatic load_operands(int kind);
    logic [31:0] xv;
    logic [31:0] wv;
    for (int i = 0; i < int'(Dim); i++) begin
      for (int j = 0; j < int'(Dim); j++) begin
        xv = $random(seed);
        wv = $random(seed);
        if (kind == 1) begin
          xv = (i == j) ? 32'd1 : 32'd0;
        end else if (kind == 2) begin
          xv = 32'(1) << (DataW - 1);
          wv = xv;
        end
        apb_xfer(1'b1, elem_addr(mmul_pkg::XBase, i, j), xv);
        apb_xfer(1'b1, elem_addr(mmul_pkg::WBase, i, j), wv);
      end
    end
  endtask

  task automatic read_z();
    for (int i = 0; i < int'(Elems); i++) begin
      apb_xfer(1'b0, elem_addr(mmul_pkg::ZBase, 0, i), '0);
    end
  endtask

  task automatic run_job(int kind);
    load_operands(kind);
    apb_xfer(1'b1, mmul_pkg::CtrlAddr, 32'h1);
    wait_done();
    read_z();
  endtask

  initial begin
    rst_ni    = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (irq_o !== 1'b0 || pready_o !== 1'b0) begin
      tb_errs++;
      $display("** Error: irq_o/pready_o after reset: got %h/%h, expected 0/0",
               irq_o, pready_o);
    end
    apb_xfer(1'b0, mmul_pkg::StatusAddr, '0);

    // Sign extension, then rejected writes; the aliases of X(0,0) must not land
    apb_xfer(1'b1, elem_addr(mmul_pkg::XBase, 0, 0), 32'h0000_00f3);
    apb_xfer(1'b1, elem_addr(mmul_pkg::WBase, 1, 2), 32'h0000_007f);
    apb_xfer(1'b1, elem_addr(mmul_pkg::XBase, 1, 1), 32'h1234_5680);
    apb_xfer(1'b0, elem_addr(mmul_pkg::XBase, 0, 0), '0);
    apb_xfer(1'b0, elem_addr(mmul_pkg::WBase, 1, 2), '0);
    apb_xfer(1'b0, elem_addr(mmul_pkg::XBase, 1, 1), '0);
    apb_xfer(1'b1, mmul_pkg::ZBase, 32'hdead_beef);
    apb_xfer(1'b1, 12'h040, 32'h0000_0001);
    apb_xfer(1'b1, mmul_pkg::XBase + 12'(4 * Elems), 32'h0000_0011);
    apb_xfer(1'b0, 12'h7fc, '0);
    apb_xfer(1'b0, elem_addr(mmul_pkg::XBase, 0, 0), '0);

    for (int n = 0; n < int'(RandJobs); n++) begin
      run_job(0);
    end
    run_job(1);
    run_job(2);

    // Second start right behind the first, while the job runs
    load_operands(0);
    apb_xfer(1'b1, mmul_pkg::CtrlAddr, 32'h1);
    apb_xfer(1'b1, mmul_pkg::CtrlAddr, 32'h1);
    wait_done();
    read_z();

    // Operand write while busy
    apb_xfer(1'b1, mmul_pkg::CtrlAddr, 32'h1);
    apb_xfer(1'b1, elem_addr(mmul_pkg::XBase, 0, 0), 32'h0000_0055);
    wait_done();
    read_z();
    apb_xfer(1'b0, elem_addr(mmul_pkg::XBase, 0, 0), '0);

    repeat (4) @(posedge clk_i);
    $display("Errors: monitor %0d, testbench %0d, assertions %0d", mon_errs, tb_errs,
             DUT.port_checker.fail_cnt);
    if (mon_errs + tb_errs + DUT.port_checker.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    repeat (200 * PlannedXfers) @(posedge clk_i);
    $display("Timeout: no verdict after %0d cycles, a transfer or job never completed",
             200 * PlannedXfers);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/mmul_pkg.sv
rtl/mmul_apb_regs.sv
rtl/mmul_operand_feeder.sv
rtl/mmul_row_engine.sv
rtl/mmul_result_drain.sv
rtl/mmul_wrap.sv
test/mmul_checker.sv
test/mmul_monitor.sv
test/mmul_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; status is nonzero unless the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module mmul_tb -f build.f -o mmul_sim &&
./obj_dir/mmul_sim | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null &&
echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }
